// File: Bender.yml
package:
  name: mips_core

sources:
  - files:
      - source/mips_isa_pkg.sv
      - source/mips_core_pkg.sv
      - source/mips_fetch.sv
      - source/mips_decode.sv
      - source/mips_execute.sv
      - source/mips_memory.sv
      - source/mips_core_top.sv
  - target: test
    files:
      - bench/mips_core_chk.sv
      - bench/mips_core_tb.sv

// File: bench/mips_core_chk.sv
`default_nettype none

module mips_core_chk
  import mips_isa_pkg::*;
#(
  parameter int unsigned IMEM_AW = 8
) (
  input wire logic               clk,
  input wire logic               rst_n_i,
  input wire logic [IMEM_AW-1:0] imem_addr_i,
  input wire logic               wb_en_i,
  input wire reg_idx_t           wb_reg_i
);

  timeunit 1ns;
  timeprecision 1ps;

  a_wb_quiet_in_reset: assert property (@(posedge clk) !rst_n_i |-> !wb_en_i)
    else $error("writeback enable high during reset");

  // r0 writes are dropped before the port
  a_wb_reg_nonzero: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_en_i |-> (wb_reg_i != '0))
    else $error("writeback to register zero");

  // hold on stall, else one word forward
  a_fetch_step: assert property (@(posedge clk) disable iff (!rst_n_i)
    (imem_addr_i == $past(imem_addr_i)) || (imem_addr_i == $past(imem_addr_i) + 1'b1))
    else $error("fetch address jumped");

endmodule

bind mips_core_top mips_core_chk #(
  .IMEM_AW ( IMEM_AW )
) chk_u1 (
  .clk         ( clk         ),
  .rst_n_i     ( rst_n_i     ),
  .imem_addr_i ( imem_addr_o ),
  .wb_en_i     ( wb_en_o     ),
  .wb_reg_i    ( wb_reg_o    )
);

`default_nettype wire

// File: bench/mips_core_tb.sv
`default_nettype none

module mips_core_tb
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned IMEM_AW = 8;
  localparam int unsigned DMEM_AW = 6;

  logic               clk = 1'b0;
  logic               rst_n_i;
  instr_t             imem_data_i;
  logic [IMEM_AW-1:0] imem_addr_o;
  logic               wb_en_o;
  reg_idx_t           wb_reg_o;
  word_t              wb_data_o;

  instr_t             prog [$];       // program table
  reg_idx_t           prog_dest [$];  // expected write target or 0 for none
  reg_idx_t           exp_reg [$];
  word_t              exp_data [$];
  logic [15:0]        lfsr_q = 16'd89;
  int                 fetch_repeats = 0;
  logic [IMEM_AW-1:0] last_addr;

  mips_core_top #(
    .IMEM_AW ( IMEM_AW ),
    .DMEM_AW ( DMEM_AW )
  ) dut (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .imem_data_i ( imem_data_i ),
    .imem_addr_o ( imem_addr_o ),
    .wb_en_o     ( wb_en_o     ),
    .wb_reg_o    ( wb_reg_o    ),
    .wb_data_o   ( wb_data_o   )
  );

  always #10 clk = ~clk;

  task automatic report_and_stop(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string what);
    if (got !== exp)
      report_and_stop($sformatf("mismatch at %0t: %s got r%0d expected r%0d",
                                $time, what, got, exp));
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp)
      report_and_stop($sformatf("mismatch at %0t: %s got %h expected %h",
                                $time, what, got, exp));
  endtask

  task automatic check_addr(input logic [IMEM_AW-1:0] got, input logic [IMEM_AW-1:0] exp,
                            input string what);
    if (got !== exp)
      report_and_stop($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_and_stop($sformatf("mismatch at %0t: %s got %b expected %b",
                                $time, what, got, exp));
  endtask

  // galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) return (s >> 1) ^ 16'hb400;
    return s >> 1;
  endfunction

  task automatic take_imm(output logic [15:0] imm);
    imm = '0;
    for (int b = 0; b < 16; b++) begin
      imm    = {imm[14:0], lfsr_q[0]};  // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic instr_t enc_r(funct_t fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
    instr_t w;
    w.r = '{OP_RTYPE, rs, rt, rd, 5'd0, fn};
    return w;
  endfunction

  function automatic instr_t enc_i(opcode_t op, reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
    instr_t w;
    w.i = '{op, rs, rt, imm};
    return w;
  endfunction

  task automatic push_entry(input instr_t w, input reg_idx_t dest);
    prog.push_back(w);
    prog_dest.push_back(dest);
  endtask

  task automatic build_program();
    logic [15:0] imm;
    push_entry(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd7), 5'd1);
    push_entry(enc_i(OP_ADDI, 5'd2, 5'd0, 16'hfffd), 5'd2);  // -3
    push_entry(enc_i(OP_ADDI, 5'd3, 5'd0, 16'd100), 5'd3);
    push_entry(enc_i(OP_ADDI, 5'd4, 5'd0, 16'h0f0f), 5'd4);
    push_entry(enc_i(OP_ADDI, 5'd5, 5'd0, 16'h00ff), 5'd5);
    // independent R-type
    push_entry(enc_r(FN_ADD, 5'd6, 5'd1, 5'd3), 5'd6);
    push_entry(enc_r(FN_SUB, 5'd7, 5'd1, 5'd3), 5'd7);
    push_entry(enc_r(FN_AND, 5'd8, 5'd4, 5'd5), 5'd8);
    push_entry(enc_r(FN_OR, 5'd9, 5'd4, 5'd5), 5'd9);
    push_entry(enc_r(FN_SLT, 5'd10, 5'd2, 5'd1), 5'd10);  // negative operand
    push_entry(enc_r(FN_SLT, 5'd11, 5'd1, 5'd2), 5'd11);
    // forwarding at distance 1 and 2
    push_entry(enc_r(FN_ADD, 5'd12, 5'd1, 5'd1), 5'd12);
    push_entry(enc_r(FN_SUB, 5'd13, 5'd12, 5'd2), 5'd13);
    push_entry(enc_i(OP_ADDI, 5'd14, 5'd12, 16'd5), 5'd14);
    push_entry(enc_r(FN_OR, 5'd15, 5'd13, 5'd14), 5'd15);
    push_entry(enc_i(OP_ADDI, 5'd15, 5'd15, 16'hffff), 5'd15);
    // store and load followed by the single load-use pair
    push_entry(enc_i(OP_ADDI, 5'd16, 5'd0, 16'h0055), 5'd16);
    push_entry(enc_i(OP_SW, 5'd16, 5'd0, 16'd8), 5'd0);
    push_entry(enc_i(OP_LW, 5'd17, 5'd0, 16'd8), 5'd17);
    push_entry(enc_r(FN_SUB, 5'd18, 5'd17, 5'd1), 5'd18);
    push_entry(enc_i(OP_SW, 5'd18, 5'd3, 16'd12), 5'd0);
    push_entry(enc_i(OP_LW, 5'd19, 5'd0, 16'd112), 5'd19);
    push_entry(enc_r(FN_ADD, 5'd0, 5'd1, 5'd1), 5'd0);
    // random immediates
    for (int k = 21; k <= 24; k++) begin
      take_imm(imm);
      push_entry(enc_i(OP_ADDI, reg_idx_t'(k), 5'd2, imm), reg_idx_t'(k));
    end
    take_imm(imm);
    push_entry(enc_i(OP_ADDI, 5'd0, 5'd1, imm), 5'd0);
    push_entry(enc_r(FN_ADD, 5'd25, 5'd21, 5'd19), 5'd25);
  endtask

  // ISA model stepping through the table in program order
  task automatic run_model();
    word_t    mrf [32];
    word_t    mdm [int];
    instr_t   ins;
    word_t    a;
    word_t    b;
    word_t    imm;
    word_t    val;
    reg_idx_t dest;
    int       key;
    foreach (mrf[r]) mrf[r] = '0;
    for (int n = 0; n < prog.size(); n++) begin
      ins  = prog[n];
      a    = mrf[ins.i.rs];
      b    = mrf[ins.i.rt];
      imm  = {{16{ins.i.imm16[15]}}, ins.i.imm16};
      key  = int'((a + imm) >> 2);
      dest = '0;
      val  = '0;
      case (ins.i.opcode)
        OP_RTYPE: begin
          dest = ins.r.rd;
          case (ins.r.funct)
            FN_ADD:  val = a + b;
            FN_SUB:  val = a - b;
            FN_AND:  val = a & b;
            FN_OR:   val = a | b;
            FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: report_and_stop($sformatf("program entry %0d has no valid funct", n));
          endcase
        end
        OP_ADDI: begin
          dest = ins.i.rt;
          val  = a + imm;
        end
        OP_LW: begin
          dest = ins.i.rt;
          if (!mdm.exists(key))
            report_and_stop($sformatf("program entry %0d loads a word never stored", n));
          val = mdm[key];
        end
        OP_SW: mdm[key] = b;
        default: report_and_stop($sformatf("program entry %0d has no valid opcode", n));
      endcase
      if (dest != prog_dest[n])
        report_and_stop($sformatf("program entry %0d lists the wrong write target", n));
      if (dest != '0) begin  // r0 writes vanish
        mrf[dest] = val;
        exp_reg.push_back(dest);
        exp_data.push_back(val);
      end
    end
  endtask

  // same-cycle instruction answer
  task automatic drive_imem();
    forever begin
      @(negedge clk);
      if (int'(imem_addr_o) < prog.size()) imem_data_i = prog[imem_addr_o];
      else imem_data_i = '0;
    end
  endtask

  task automatic count_repeats();
    forever begin
      @(negedge clk);
      if (imem_addr_o == last_addr) fetch_repeats++;
      last_addr = imem_addr_o;
    end
  endtask

  task automatic wait_wb(input int idx);
    int cyc;
    cyc = 0;
    do begin
      @(negedge clk);
      cyc++;
    end while ((wb_en_o !== 1'b1) && (cyc < 20));
    if (wb_en_o !== 1'b1)
      report_and_stop($sformatf("no writeback arrived within 20 cycles for entry %0d", idx));
  endtask

  initial begin
    rst_n_i     = 1'b0;
    imem_data_i = '0;
    build_program();
    run_model();
    fork
      drive_imem();
    join_none
    repeat (16) begin
      @(negedge clk);
      check_flag(wb_en_o, 1'b0, "wb_en_o in reset");
      check_addr(imem_addr_o, '0, "fetch address in reset");
    end
    rst_n_i = 1'b1;
    @(negedge clk);
    check_addr(imem_addr_o, 8'd1, "fetch address one cycle after reset");
    last_addr = imem_addr_o;
    fork
      count_repeats();
    join_none
    for (int k = 0; k < exp_reg.size(); k++) begin
      wait_wb(k);
      check_reg(wb_reg_o, exp_reg[k], $sformatf("writeback %0d register", k));
      check_word(wb_data_o, exp_data[k], $sformatf("writeback %0d data", k));
    end
    for (int k = 0; k < 10; k++) begin  // trailing nops stay quiet
      @(negedge clk);
      if (wb_en_o !== 1'b0)
        report_and_stop("an extra writeback arrived after the last expected one");
    end
    if (fetch_repeats != 1) begin
      report_and_stop($sformatf("mismatch at %0t: fetch address held %0d times, expected 1",
                                $time, fetch_repeats));
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: list.f
source/mips_isa_pkg.sv
source/mips_core_pkg.sv
source/mips_fetch.sv
source/mips_decode.sv
source/mips_execute.sv
source/mips_memory.sv
source/mips_core_top.sv
bench/mips_core_chk.sv
bench/mips_core_tb.sv

// File: source/mips_core_pkg.sv
`default_nettype none

package mips_core_pkg;

  localparam int unsigned XLEN = 32;  // bits per register

  typedef logic [XLEN-1:0] word_t;

  // ALU class from the main decode
  typedef enum logic [1:0] {
    ALU_OP_ADD   = 2'b00,  // address calc and addi
    ALU_OP_SUB   = 2'b01,
    ALU_OP_FUNCT = 2'b10   // R-type, look at funct
  } alu_op_t;

  // classic MIPS ALU control codes
  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } alu_ctrl_t;

  // where an EX operand comes from
  typedef enum logic [1:0] {
    FWD_REG   = 2'b00,  // ID/EX register value
    FWD_EXMEM = 2'b01,  // result one ahead
    FWD_MEMWB = 2'b10   // writeback value
  } fwd_sel_t;

endpackage

`default_nettype wire

// File: source/mips_core_top.sv
`default_nettype none

module mips_core_top
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
#(
  parameter int unsigned IMEM_AW = 8,
  parameter int unsigned DMEM_AW = 6
) (
  input  wire logic          clk,
  input  wire logic          rst_n_i,
  input  wire instr_t        imem_data_i,
  output logic [IMEM_AW-1:0] imem_addr_o,
  output logic               wb_en_o,
  output reg_idx_t           wb_reg_o,
  output word_t              wb_data_o
);

  logic     stall;
  instr_t   if_id_instr;
  logic     id_reg_write;
  logic     id_mem_to_reg;
  logic     id_mem_write;
  logic     id_alu_src;
  logic     id_reg_dst;
  alu_op_t  id_alu_op;
  word_t    id_rs_val;
  word_t    id_rt_val;
  word_t    id_imm;
  funct_t   id_funct;
  reg_idx_t id_rs;
  reg_idx_t id_rt;
  reg_idx_t id_rd;
  logic     ex_mem_to_reg;
  reg_idx_t ex_dest;
  logic     mem_reg_write;
  logic     mem_mem_to_reg;
  logic     mem_write;
  word_t    mem_alu_result;
  word_t    mem_store_data;
  reg_idx_t mem_dest;

  mips_fetch #(
    .IMEM_AW ( IMEM_AW )
  ) fetch_u1 (
    .clk         ( clk         ),
    .rst_n_i     ( rst_n_i     ),
    .stall_i     ( stall       ),
    .imem_data_i ( imem_data_i ),
    .imem_addr_o ( imem_addr_o ),
    .instr_o     ( if_id_instr )
  );

  mips_decode decode_u1 (
    .clk             ( clk           ),
    .rst_n_i         ( rst_n_i       ),
    .instr_i         ( if_id_instr   ),
    .ex_mem_to_reg_i ( ex_mem_to_reg ),
    .ex_rt_i         ( ex_dest       ),  // load target in EX
    .wb_en_i         ( wb_en_o       ),
    .wb_dest_i       ( wb_reg_o      ),
    .wb_data_i       ( wb_data_o     ),
    .stall_o         ( stall         ),
    .reg_write_o     ( id_reg_write  ),
    .mem_to_reg_o    ( id_mem_to_reg ),
    .mem_write_o     ( id_mem_write  ),
    .alu_src_o       ( id_alu_src    ),
    .reg_dst_o       ( id_reg_dst    ),
    .alu_op_o        ( id_alu_op     ),
    .rs_val_o        ( id_rs_val     ),
    .rt_val_o        ( id_rt_val     ),
    .imm_o           ( id_imm        ),
    .funct_o         ( id_funct      ),
    .rs_o            ( id_rs         ),
    .rt_o            ( id_rt         ),
    .rd_o            ( id_rd         )
  );

  mips_execute execute_u1 (
    .clk              ( clk            ),
    .rst_n_i          ( rst_n_i        ),
    .reg_write_i      ( id_reg_write   ),
    .mem_to_reg_i     ( id_mem_to_reg  ),
    .mem_write_i      ( id_mem_write   ),
    .alu_src_i        ( id_alu_src     ),
    .reg_dst_i        ( id_reg_dst     ),
    .alu_op_i         ( id_alu_op      ),
    .rs_val_i         ( id_rs_val      ),
    .rt_val_i         ( id_rt_val      ),
    .imm_i            ( id_imm         ),
    .funct_i          ( id_funct       ),
    .rs_i             ( id_rs          ),
    .rt_i             ( id_rt          ),
    .rd_i             ( id_rd          ),
    .wb_en_i          ( wb_en_o        ),
    .wb_dest_i        ( wb_reg_o       ),
    .wb_data_i        ( wb_data_o      ),
    .ex_mem_to_reg_o  ( ex_mem_to_reg  ),
    .ex_dest_o        ( ex_dest        ),
    .mem_reg_write_o  ( mem_reg_write  ),
    .mem_mem_to_reg_o ( mem_mem_to_reg ),
    .mem_write_o      ( mem_write      ),
    .alu_result_o     ( mem_alu_result ),
    .store_data_o     ( mem_store_data ),
    .mem_dest_o       ( mem_dest       )
  );

  // writeback also drives the observation port
  mips_memory #(
    .DMEM_AW ( DMEM_AW )
  ) memory_u1 (
    .clk          ( clk            ),
    .rst_n_i      ( rst_n_i        ),
    .reg_write_i  ( mem_reg_write  ),
    .mem_to_reg_i ( mem_mem_to_reg ),
    .mem_write_i  ( mem_write      ),
    .alu_result_i ( mem_alu_result ),
    .store_data_i ( mem_store_data ),
    .dest_i       ( mem_dest       ),
    .wb_en_o      ( wb_en_o        ),
    .wb_dest_o    ( wb_reg_o       ),
    .wb_data_o    ( wb_data_o      )
  );

endmodule

`default_nettype wire

// File: source/mips_decode.sv
`default_nettype none

module mips_decode
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n_i,
  input  wire instr_t   instr_i,
  input  wire logic     ex_mem_to_reg_i,
  input  wire reg_idx_t ex_rt_i,
  input  wire logic     wb_en_i,
  input  wire reg_idx_t wb_dest_i,
  input  wire word_t    wb_data_i,
  output logic          stall_o,
  output logic          reg_write_o,
  output logic          mem_to_reg_o,
  output logic          mem_write_o,
  output logic          alu_src_o,
  output logic          reg_dst_o,
  output alu_op_t       alu_op_o,
  output word_t         rs_val_o,
  output word_t         rt_val_o,
  output word_t         imm_o,
  output funct_t        funct_o,
  output reg_idx_t      rs_o,
  output reg_idx_t      rt_o,
  output reg_idx_t      rd_o
);

  word_t    rf_q [2**REG_IDX_W];
  reg_idx_t rs;
  reg_idx_t rt;
  logic     reg_write_d;
  logic     mem_to_reg_d;
  logic     mem_write_d;
  logic     alu_src_d;
  logic     reg_dst_d;
  alu_op_t  alu_op_d;
  logic     uses_rt;     // rt is a source operand
  word_t    rs_val_d;
  word_t    rt_val_d;
  word_t    imm_d;

  assign rs = instr_i.i.rs;
  assign rt = instr_i.i.rt;

  // main control
  always_comb begin
    reg_write_d  = 1'b0;
    mem_to_reg_d = 1'b0;
    mem_write_d  = 1'b0;
    alu_src_d    = 1'b0;
    reg_dst_d    = 1'b0;
    alu_op_d     = ALU_OP_ADD;
    uses_rt      = 1'b0;
    case (instr_i.i.opcode)
      OP_RTYPE: begin
        reg_write_d = 1'b1;
        reg_dst_d   = 1'b1;
        alu_op_d    = ALU_OP_FUNCT;
        uses_rt     = 1'b1;
      end
      OP_ADDI: begin
        reg_write_d = 1'b1;
        alu_src_d   = 1'b1;
      end
      OP_LW: begin
        reg_write_d  = 1'b1;
        mem_to_reg_d = 1'b1;
        alu_src_d    = 1'b1;
      end
      OP_SW: begin
        mem_write_d = 1'b1;
        alu_src_d   = 1'b1;
        uses_rt     = 1'b1;  // store data
      end
      default: ;  // unknown opcode runs as a nop
    endcase
  end

  // load in EX feeding this instruction, hold one cycle
  assign stall_o = ex_mem_to_reg_i && (ex_rt_i != '0) &&
                   ((ex_rt_i == rs) || (uses_rt && (ex_rt_i == rt)));

  // register file, r0 reads zero, write bypassed to reads
  always_comb begin
    rs_val_d = rf_q[rs];
    rt_val_d = rf_q[rt];
    if (wb_en_i && (wb_dest_i == rs)) rs_val_d = wb_data_i;
    if (wb_en_i && (wb_dest_i == rt)) rt_val_d = wb_data_i;
    if (rs == '0) rs_val_d = '0;
    if (rt == '0) rt_val_d = '0;
  end

  always_ff @(posedge clk) begin
    if (wb_en_i) begin
      rf_q[wb_dest_i] <= wb_data_i;  // wb_en never set for r0
    end
  end

  assign imm_d = {{(XLEN-IMM_W){instr_i.i.imm16[IMM_W-1]}}, instr_i.i.imm16};

  // ID/EX controls, bubble on stall
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_write_o  <= 1'b0;
      mem_to_reg_o <= 1'b0;
      mem_write_o  <= 1'b0;
      alu_src_o    <= 1'b0;
      reg_dst_o    <= 1'b0;
      alu_op_o     <= ALU_OP_ADD;
    end else if (stall_o) begin
      reg_write_o  <= 1'b0;
      mem_to_reg_o <= 1'b0;
      mem_write_o  <= 1'b0;
      alu_src_o    <= 1'b0;
      reg_dst_o    <= 1'b0;
      alu_op_o     <= ALU_OP_ADD;
    end else begin
      reg_write_o  <= reg_write_d;
      mem_to_reg_o <= mem_to_reg_d;
      mem_write_o  <= mem_write_d;
      alu_src_o    <= alu_src_d;
      reg_dst_o    <= reg_dst_d;
      alu_op_o     <= alu_op_d;
    end
  end

  // ID/EX operands and indices
  always_ff @(posedge clk) begin
    rs_val_o <= rs_val_d;
    rt_val_o <= rt_val_d;
    imm_o    <= imm_d;
    funct_o  <= instr_i.r.funct;
    rs_o     <= rs;
    rt_o     <= rt;
    rd_o     <= instr_i.r.rd;
  end

endmodule

`default_nettype wire

// File: source/mips_execute.sv
`default_nettype none

module mips_execute
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     rst_n_i,
  input  wire logic     reg_write_i,
  input  wire logic     mem_to_reg_i,
  input  wire logic     mem_write_i,
  input  wire logic     alu_src_i,
  input  wire logic     reg_dst_i,
  input  wire alu_op_t  alu_op_i,
  input  wire word_t    rs_val_i,
  input  wire word_t    rt_val_i,
  input  wire word_t    imm_i,
  input  wire funct_t   funct_i,
  input  wire reg_idx_t rs_i,
  input  wire reg_idx_t rt_i,
  input  wire reg_idx_t rd_i,
  input  wire logic     wb_en_i,
  input  wire reg_idx_t wb_dest_i,
  input  wire word_t    wb_data_i,
  output logic          ex_mem_to_reg_o,
  output reg_idx_t      ex_dest_o,
  output logic          mem_reg_write_o,
  output logic          mem_mem_to_reg_o,
  output logic          mem_write_o,
  output word_t         alu_result_o,
  output word_t         store_data_o,
  output reg_idx_t      mem_dest_o
);

  fwd_sel_t  fwd_a;
  fwd_sel_t  fwd_b;
  fwd_sel_t  fwd_st;
  word_t     opnd_a;
  word_t     opnd_b;
  word_t     store_d;
  alu_ctrl_t alu_ctrl;
  word_t     alu_res;

  // younger producer (EX/MEM) has priority, r0 is never forwarded
  function automatic fwd_sel_t fwd_select(input reg_idx_t src);
    if (src == '0) return FWD_REG;
    if (mem_reg_write_o && (mem_dest_o == src)) return FWD_EXMEM;
    if (wb_en_i && (wb_dest_i == src)) return FWD_MEMWB;
    return FWD_REG;
  endfunction

  function automatic word_t fwd_pick(input fwd_sel_t sel, input word_t reg_val);
    case (sel)
      FWD_EXMEM: return alu_result_o;
      FWD_MEMWB: return wb_data_i;
      default:   return reg_val;
    endcase
  endfunction

  always_comb begin
    fwd_a   = fwd_select(rs_i);
    fwd_b   = alu_src_i ? FWD_REG : fwd_select(rt_i);  // immediate needs no forward
    fwd_st  = fwd_select(rt_i);                        // sw data path
    opnd_a  = fwd_pick(fwd_a, rs_val_i);
    opnd_b  = alu_src_i ? imm_i : fwd_pick(fwd_b, rt_val_i);
    store_d = fwd_pick(fwd_st, rt_val_i);
  end

  // ALU control
  always_comb begin
    case (alu_op_i)
      ALU_OP_SUB: alu_ctrl = ALU_SUB;
      ALU_OP_FUNCT: begin
        case (funct_i)
          FN_SUB:  alu_ctrl = ALU_SUB;
          FN_AND:  alu_ctrl = ALU_AND;
          FN_OR:   alu_ctrl = ALU_OR;
          FN_SLT:  alu_ctrl = ALU_SLT;
          default: alu_ctrl = ALU_ADD;
        endcase
      end
      default: alu_ctrl = ALU_ADD;
    endcase
  end

  always_comb begin
    case (alu_ctrl)
      ALU_AND: alu_res = opnd_a & opnd_b;
      ALU_OR:  alu_res = opnd_a | opnd_b;
      ALU_SUB: alu_res = opnd_a - opnd_b;
      ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, ($signed(opnd_a) < $signed(opnd_b))};
      default: alu_res = opnd_a + opnd_b;
    endcase
  end

  assign ex_dest_o       = reg_dst_i ? rd_i : rt_i;  // rd for R-type
  assign ex_mem_to_reg_o = mem_to_reg_i;             // load-use check in decode

  // EX/MEM
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_reg_write_o  <= 1'b0;
      mem_mem_to_reg_o <= 1'b0;
      mem_write_o      <= 1'b0;
    end else begin
      mem_reg_write_o  <= reg_write_i;
      mem_mem_to_reg_o <= mem_to_reg_i;
      mem_write_o      <= mem_write_i;
    end
  end

  always_ff @(posedge clk) begin
    alu_result_o <= alu_res;
    store_data_o <= store_d;
    mem_dest_o   <= ex_dest_o;
  end

endmodule

`default_nettype wire

// File: source/mips_fetch.sv
`default_nettype none

module mips_fetch
  import mips_isa_pkg::*;
#(
  parameter int unsigned IMEM_AW = 8
) (
  input  wire logic          clk,
  input  wire logic          rst_n_i,
  input  wire logic          stall_i,
  input  wire instr_t        imem_data_i,
  output logic [IMEM_AW-1:0] imem_addr_o,
  output instr_t             instr_o
);

  logic [IMEM_AW-1:0] pc_q;     // word address
  instr_t             if_id_q;

  // pc steps one word per cycle, frozen on load-use
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= '0;
    end else if (!stall_i) begin
      pc_q <= pc_q + 1'b1;
    end
  end

  // IF/ID instruction register
  // all zeros is add r0,r0,r0 which never writes back
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_q <= '0;
    end else if (!stall_i) begin
      if_id_q <= imem_data_i;  // same-cycle answer from outside
    end
  end

  assign imem_addr_o = pc_q;
  assign instr_o     = if_id_q;

endmodule

`default_nettype wire

// File: source/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

  localparam int unsigned OPCODE_W  = 6;
  localparam int unsigned REG_IDX_W = 5;
  localparam int unsigned SHAMT_W   = 5;
  localparam int unsigned FUNCT_W   = 6;
  localparam int unsigned IMM_W     = 16;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // only the opcodes this core executes
  typedef enum logic [OPCODE_W-1:0] {
    OP_RTYPE = 6'h00,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_t;

  typedef enum logic [FUNCT_W-1:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_t;

  typedef struct packed {
    opcode_t            opcode;
    reg_idx_t           rs;
    reg_idx_t           rt;
    reg_idx_t           rd;
    logic [SHAMT_W-1:0] shamt;  // unused, no shifts
    funct_t             funct;
  } instr_r_t;

  typedef struct packed {
    opcode_t          opcode;
    reg_idx_t         rs;
    reg_idx_t         rt;
    logic [IMM_W-1:0] imm16;
  } instr_i_t;

  // same fetched word, seen as R or I format
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_t;

endpackage

`default_nettype wire

// File: source/mips_memory.sv
`default_nettype none

module mips_memory
  import mips_isa_pkg::*;
  import mips_core_pkg::*;
#(
  parameter int unsigned DMEM_AW = 6
) (
  input  wire logic     clk,
  input  wire logic     rst_n_i,
  input  wire logic     reg_write_i,
  input  wire logic     mem_to_reg_i,
  input  wire logic     mem_write_i,
  input  wire word_t    alu_result_i,
  input  wire word_t    store_data_i,
  input  wire reg_idx_t dest_i,
  output logic          wb_en_o,
  output reg_idx_t      wb_dest_o,
  output word_t         wb_data_o
);

  word_t              dmem_q [2**DMEM_AW];
  logic [DMEM_AW-1:0] word_addr;
  word_t              load_data;
  logic               mem_to_reg_q;
  word_t              load_q;
  word_t              alu_q;

  assign word_addr = alu_result_i[DMEM_AW+1:2];  // byte address to word index
  assign load_data = dmem_q[word_addr];          // async read

  always_ff @(posedge clk) begin
    if (mem_write_i) begin
      dmem_q[word_addr] <= store_data_i;
    end
  end

  // MEM/WB
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_en_o      <= 1'b0;
      mem_to_reg_q <= 1'b0;
    end else begin
      wb_en_o      <= reg_write_i && (dest_i != '0);  // writes to r0 dropped here
      mem_to_reg_q <= mem_to_reg_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_dest_o <= dest_i;
    load_q    <= load_data;
    alu_q     <= alu_result_i;
  end

  assign wb_data_o = mem_to_reg_q ? load_q : alu_q;

endmodule

`default_nettype wire
